//--- verilog/rv32i_types.sv
`default_nettype none

package rv32i_types;

	// Core data path word, used for addresses, data and counts.
	typedef logic [31:0] rv32i_word;

	// ************************************************************************
	// Backing data memory
	// ************************************************************************
	localparam int MEM_WORDS   = 256;                // Depth in words.
	localparam int MEM_IDX_W   = $clog2(MEM_WORDS);  // Word index, addr[9:2].
	localparam int MEM_LATENCY = 3;                  // Accept to resp, in cycles.

	typedef logic [$clog2(MEM_LATENCY)-1:0] mem_lat_t;

	typedef enum logic [1:0] {
		mem_idle,
		mem_busy,
		mem_done
	} mem_state_e;

endpackage : rv32i_types

`default_nettype wire

//--- verilog/perf_types.sv
`default_nettype none

package perf_types;

	localparam int NUM_COUNTERS = 12;

	// Low address byte of each counter, counter i sits at 0xC0 + 4*i.
	typedef enum logic [7:0] {
		icache_hit       = 8'hC0,
		icache_miss      = 8'hC4,
		dcache_hit       = 8'hC8,
		dcache_miss      = 8'hCC,
		l2_hit           = 8'hD0,
		l2_miss          = 8'hD4,
		ewb_writes       = 8'hD8,
		branch_total     = 8'hDC,
		branch_correct   = 8'hE0,
		branch_incorrect = 8'hE4,
		prefetch_hit     = 8'hE8,
		prefetch_read    = 8'hEC
	} counter_addr;

	// One word per counter, indexed by counter number.
	typedef rv32i_types::rv32i_word [NUM_COUNTERS-1:0] perf_count_array;

	// One bit per counter, same order as the tags.
	typedef logic [NUM_COUNTERS-1:0] perf_event_vec;

endpackage : perf_types

`default_nettype wire

//--- verilog/counter.sv
`timescale 1ns/1ps
`default_nettype none

module counter (
	input  rv32i_types::rv32i_word      mem_addr,
	input  logic                        mem_read,
	input  logic                        mem_write,
	input  rv32i_types::rv32i_word      mem_rdata_in,
	input  logic                        mem_resp_in,
	input  perf_types::perf_count_array counts,
	output logic                        read_b_counter,
	output logic                        write_counter,
	output logic                        mem_resp,
	output rv32i_types::rv32i_word      mem_rdata_out,
	output perf_types::perf_event_vec   clear
);

	import rv32i_types::*;
	import perf_types::*;

	counter_addr tag;
	logic        addr_hit;
	logic [3:0]  ctr_idx;
	rv32i_word   count_sel;
	logic        counter_resp;

	// ************************************************************************
	// Tag decode
	// ************************************************************************

	// Only the low byte is decoded, upper bits alias.
	assign tag = counter_addr'(mem_addr[7:0]);

	always_comb begin
		case (tag)
			icache_hit,
			icache_miss,
			dcache_hit,
			dcache_miss,
			l2_hit,
			l2_miss,
			ewb_writes,
			branch_total,
			branch_correct,
			branch_incorrect,
			prefetch_hit,
			prefetch_read:
				addr_hit = 1'b1;
			default:
				addr_hit = 1'b0;
		endcase
	end

	// Tags are 0xC0 + 4*i, so bits 5:2 give i directly.
	assign ctr_idx = mem_addr[5:2];

	// ************************************************************************
	// Counter side
	// ************************************************************************

	always_comb begin
		count_sel = '0;
		if (addr_hit)
			count_sel = counts[ctr_idx];  // Index below 12 on a hit.
	end

	always_comb begin
		clear = '0;
		if (mem_write & addr_hit)
			clear[ctr_idx] = 1'b1;  // One-cycle clear pulse.
	end

	assign counter_resp = addr_hit & (mem_read | mem_write);  // Same-cycle answer.

	// ************************************************************************
	// Memory side
	// ************************************************************************

	assign read_b_counter = mem_read & ~addr_hit;
	assign write_counter  = mem_write & ~addr_hit;

	assign mem_resp      = counter_resp | mem_resp_in;
	assign mem_rdata_out = (mem_read & addr_hit) ? count_sel : mem_rdata_in;

	// The requester never reads and writes at once, so neither do we.
	always_comb begin
		assert #0 (!(read_b_counter && write_counter))
			else $error("counter: read and write forwarded to memory together");
	end

endmodule : counter

`default_nettype wire

//--- verilog/event_counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module event_counter_bank (
	input  logic                        clk,
	input  logic                        rst_n,
	input  perf_types::perf_event_vec   events,
	input  perf_types::perf_event_vec   clear,
	output perf_types::perf_count_array counts
);

	import perf_types::*;

	// ************************************************************************
	// Counters
	// ************************************************************************

	for (genvar i = 0; i < NUM_COUNTERS; i++) begin : g_ctr

		// Clear beats a coincident event.
		always_ff @(posedge clk) begin
			if (!rst_n || clear[i]) begin
				counts[i] <= '0;
			end else if (events[i]) begin
				counts[i] <= counts[i] + 1'b1;  // Wraps at 2^32.
			end
		end

		// A clear from the decoder shows up as zero on the next read.
		a_clear_zero : assert property (
			@(posedge clk) disable iff (!rst_n)
			clear[i] |=> (counts[i] == '0)
		) else $error("event_counter_bank: counter %0d not zero after clear", i);

	end : g_ctr

endmodule : event_counter_bank

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rv32i_types::rv32i_word mem_addr,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  rv32i_types::rv32i_word mem_wdata,
	output rv32i_types::rv32i_word mem_rdata,
	output logic                   mem_resp
);

	import rv32i_types::*;

	rv32i_word            mem [MEM_WORDS];
	rv32i_word            rdata_q;
	mem_state_e           state;
	mem_lat_t             lat_cnt;
	logic [MEM_IDX_W-1:0] word_idx;
	logic                 req;
	logic                 accept;

	assign word_idx = mem_addr[MEM_IDX_W+1:2];  // Word addressed.
	assign req      = mem_read | mem_write;
	assign accept   = (state == mem_idle) & req;

	// ************************************************************************
	// Control FSM
	// ************************************************************************

	// Accept in cycle 0, busy through cycle 2, done in cycle 3.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= mem_idle;
			lat_cnt <= '0;
		end else begin
			case (state)
				mem_idle: begin
					if (req) begin
						state   <= mem_busy;
						lat_cnt <= mem_lat_t'(MEM_LATENCY - 2);
					end
				end
				mem_busy: begin
					if (lat_cnt == '0)
						state <= mem_done;
					else
						lat_cnt <= lat_cnt - 1'b1;
				end
				mem_done: begin
					state <= mem_idle;  // Requester drops or re-presents next cycle.
				end
				default: begin
					state <= mem_idle;
				end
			endcase
		end
	end

	// ************************************************************************
	// Storage
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (accept) begin
			if (mem_write)
				mem[word_idx] <= mem_wdata;  // Whole-word write.
			rdata_q <= mem[word_idx];
		end
	end

	assign mem_rdata = rdata_q;
	assign mem_resp  = (state == mem_done);

	// The core holds its request until it sees resp.
	a_req_stable : assert property (
		@(posedge clk) disable iff (!rst_n)
		(state != mem_idle) |-> ($stable(mem_addr) && $stable(mem_read)
			&& $stable(mem_write))
	) else $error("data_mem: request changed while access in flight");

endmodule : data_mem

`default_nettype wire

//--- verilog/perf_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module perf_mem_subsystem (
	input  logic                      clk,
	input  logic                      rst_n,
	input  rv32i_types::rv32i_word    mem_addr,
	input  logic                      mem_read,
	input  logic                      mem_write,
	input  rv32i_types::rv32i_word    mem_wdata,
	input  perf_types::perf_event_vec events,
	output rv32i_types::rv32i_word    mem_rdata,
	output logic                      mem_resp
);

	import rv32i_types::*;
	import perf_types::*;

	// ************************************************************************
	// Internal nets
	// ************************************************************************

	logic            read_b_counter;  // Forwarded read.
	logic            write_counter;   // Forwarded write.
	rv32i_word       dmem_rdata;
	logic            dmem_resp;
	perf_count_array counts;
	perf_event_vec   clear;

	// ************************************************************************
	// Instances
	// ************************************************************************

	counter u_counter (
		.mem_addr       (mem_addr),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_rdata_in   (dmem_rdata),
		.mem_resp_in    (dmem_resp),
		.counts         (counts),
		.read_b_counter (read_b_counter),
		.write_counter  (write_counter),
		.mem_resp       (mem_resp),
		.mem_rdata_out  (mem_rdata),
		.clear          (clear)
	);

	event_counter_bank u_counter_bank (
		.clk    (clk),
		.rst_n  (rst_n),
		.events (events),
		.clear  (clear),
		.counts (counts)
	);

	// Address and write data bypass the decoder.
	data_mem u_data_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_read  (read_b_counter),
		.mem_write (write_counter),
		.mem_wdata (mem_wdata),
		.mem_rdata (dmem_rdata),
		.mem_resp  (dmem_resp)
	);

endmodule : perf_mem_subsystem

`default_nettype wire

//--- dv/tb_perf_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_perf_mem_subsystem;

	import rv32i_types::*;
	import perf_types::*;

	localparam int CYCLE_LIMIT = 2000;  // About three times the full run.

	logic          clk = 1'b0;
	logic          rst_n;
	rv32i_word     mem_addr;
	logic          mem_read;
	logic          mem_write;
	rv32i_word     mem_wdata;
	perf_event_vec events;
	rv32i_word     mem_rdata;
	logic          mem_resp;

	rv32i_word lfsr = 32'd53;
	int        cycle_cnt = 0;
	rv32i_word exp_count [NUM_COUNTERS];  // Reference counters.
	rv32i_word mem_model [MEM_WORDS];
	rv32i_word rt_addr [16];              // Addresses written by the roundtrip test.

	perf_mem_subsystem uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_wdata (mem_wdata),
		.events    (events),
		.mem_rdata (mem_rdata),
		.mem_resp  (mem_resp)
	);

	always #5 clk = ~clk;

	// ************************************************************************
	// Reference model and timeout
	// ************************************************************************

	function automatic logic is_tag(input logic [7:0] b);
		return (b[1:0] == 2'b00) && (b >= 8'hC0) && (b <= 8'hEC);
	endfunction

	function automatic int tag_index(input logic [7:0] b);
		return (b - 8'hC0) >> 2;
	endfunction

	function automatic rv32i_word tag_addr(input int idx);
		return 32'hC0 + 4 * idx;
	endfunction

	// Clear wins over an event in the same cycle.
	always @(posedge clk) begin : count_model
		int i;
		for (i = 0; i < NUM_COUNTERS; i++) begin
			if (!rst_n || (mem_write && is_tag(mem_addr[7:0]) && tag_index(mem_addr[7:0]) == i))
				exp_count[i] <= '0;
			else if (events[i])
				exp_count[i] <= exp_count[i] + 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1);
		end
	end

	// ************************************************************************
	// Helpers
	// ************************************************************************

	// Galois LFSR stepped once per bit taken.
	function automatic rv32i_word rand_bits(input int n);
		rv32i_word val;
		logic      lsb;
		int        k;
		val = '0;
		for (k = 0; k < n; k++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'hA300_0000;
			val = {val[30:0], lsb};
		end
		return val;
	endfunction

	task automatic check_value(input string name, input rv32i_word got, input rv32i_word exp);
		assert (got === exp) else begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// One access; lat counts cycles from the request to mem_resp.
	task automatic bus_access(input logic wr, input rv32i_word addr, input rv32i_word wdata,
			output rv32i_word rdata, output int lat);
		@(posedge clk);
		mem_addr  <= addr;
		mem_read  <= ~wr;
		mem_write <= wr;
		mem_wdata <= wdata;
		lat = 0;
		@(negedge clk);
		while (!mem_resp) begin
			lat++;
			@(negedge clk);
		end
		rdata = mem_rdata;
		@(posedge clk);
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
	endtask

	task automatic check_all_counters();
		rv32i_word data;
		int        lat;
		int        i;
		for (i = 0; i < NUM_COUNTERS; i++) begin
			bus_access(1'b0, tag_addr(i), '0, data, lat);
			check_value("counter read latency", lat, 0);
			check_value($sformatf("count[%0d]", i), data, exp_count[i]);
		end
	endtask

	// ************************************************************************
	// Tests
	// ************************************************************************

	task automatic test_reset();
		@(negedge clk);
		check_value("mem_resp", mem_resp, 1'b0);
		check_all_counters();
	endtask

	task automatic test_mem_roundtrip();
		rv32i_word data;
		int        lat;
		int        i;
		logic [7:0] idx;
		for (i = 0; i < 16; i++) begin
			idx = 8'(rand_bits(8));
			while (is_tag({idx[5:0], 2'b00}))
				idx = 8'(rand_bits(8));
			rt_addr[i] = {22'd0, idx, 2'b00};
			data = rand_bits(32);
			mem_model[idx] = data;
			bus_access(1'b1, rt_addr[i], data, data, lat);
			check_value("write latency", lat, MEM_LATENCY);
		end
		for (i = 0; i < 16; i++) begin
			bus_access(1'b0, rt_addr[i], '0, data, lat);
			check_value("read latency", lat, MEM_LATENCY);
			check_value("mem_rdata", data, mem_model[rt_addr[i][9:2]]);
		end
	endtask

	task automatic test_count_events();
		rv32i_word     tally [NUM_COUNTERS];
		perf_event_vec ev;
		rv32i_word     data;
		int            lat;
		int            c;
		int            i;
		for (i = 0; i < NUM_COUNTERS; i++)
			tally[i] = exp_count[i];
		for (c = 0; c < 40; c++) begin
			ev = perf_event_vec'(rand_bits(NUM_COUNTERS));
			for (i = 0; i < NUM_COUNTERS; i++)
				tally[i] += ev[i];
			@(posedge clk);
			events <= ev;
		end
		@(posedge clk);
		events <= '0;
		for (i = 0; i < NUM_COUNTERS; i++) begin
			bus_access(1'b0, tag_addr(i), '0, data, lat);
			check_value($sformatf("count[%0d]", i), data, tally[i]);
		end
	endtask

	task automatic test_clear();
		rv32i_word data;
		int        lat;
		int        idx;
		int        j;
		for (idx = 0; idx < NUM_COUNTERS; idx++) begin
			@(posedge clk);
			events <= '1;
			@(posedge clk);
			mem_addr  <= tag_addr(idx);  // Event on the same counter in this cycle.
			mem_write <= 1'b1;
			mem_wdata <= rand_bits(32);
			@(negedge clk);
			check_value("mem_resp", mem_resp, 1'b1);
			@(posedge clk);
			events    <= '0;
			mem_write <= 1'b0;
			for (j = 0; j < NUM_COUNTERS; j++) begin
				bus_access(1'b0, tag_addr(j), '0, data, lat);
				if (j == idx)
					check_value($sformatf("count[%0d]", j), data, 32'd0);
				else
					check_value($sformatf("count[%0d]", j), data, exp_count[j]);
			end
		end
	endtask

	task automatic test_alias();
		rv32i_word addr;
		rv32i_word data;
		int        lat;
		int        i;
		for (i = 0; i < NUM_COUNTERS; i++) begin
			addr = (rand_bits(24) << 8) | tag_addr(i);
			bus_access(1'b0, addr, '0, data, lat);
			check_value("alias read latency", lat, 0);
			check_value($sformatf("alias count[%0d]", i), data, exp_count[i]);
			bus_access(1'b1, addr, rand_bits(32), data, lat);
			check_value("alias write latency", lat, 0);
		end
		check_all_counters();
		for (i = 0; i < 16; i++) begin
			bus_access(1'b0, rt_addr[i], '0, data, lat);
			check_value("mem_rdata", data, mem_model[rt_addr[i][9:2]]);
		end
	endtask

	task automatic test_counts_during_wait();
		rv32i_word data;
		int        lat;
		fork
			bus_access(1'b0, rt_addr[0], '0, data, lat);
			begin
				repeat (5) begin
					@(posedge clk);
					events <= perf_event_vec'(rand_bits(NUM_COUNTERS));
				end
				@(posedge clk);
				events <= '0;
			end
		join
		check_value("read latency", lat, MEM_LATENCY);
		check_value("mem_rdata", data, mem_model[rt_addr[0][9:2]]);
		check_all_counters();
	endtask

	// ************************************************************************
	// Main sequence
	// ************************************************************************

	initial begin
		rst_n     <= 1'b0;
		mem_addr  <= '0;
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
		mem_wdata <= '0;
		events    <= '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_mem_roundtrip();
		test_count_events();
		test_clear();
		test_alias();
		test_counts_during_wait();
		$display("all tests passed");
		$finish;
	end

endmodule : tb_perf_mem_subsystem

`default_nettype wire

//--- project.f
verilog/rv32i_types.sv
verilog/perf_types.sv
verilog/counter.sv
verilog/event_counter_bank.sv
verilog/data_mem.sv
verilog/perf_mem_subsystem.sv
dv/tb_perf_mem_subsystem.sv
